/* logic/axis_route_consts.svh */
// sizing constants for the byte-wide stream frame router
`ifndef AXIS_ROUTE_CONSTS_SVH
`define AXIS_ROUTE_CONSTS_SVH

// number of output stream ports
`define ROUTE_M_COUNT 4

// stream data width in bits
`define ROUTE_DATA_WIDTH 8

// tdest tag width, one table entry per tag value
`define ROUTE_DEST_WIDTH 3

// width of an output port index
`define ROUTE_SEL_WIDTH 2

// per-port delivered frame counter width
`define ROUTE_CNT_WIDTH 16

`endif

/* logic/axis_route_pkg.sv */
// shared types for the stream frame router
`default_nettype none

`include "axis_route_consts.svh"

package axis_route_pkg;

    // demux position relative to frame boundaries
    typedef enum logic {
        FRAME_IDLE   = 1'b0,
        FRAME_ACTIVE = 1'b1
    } frame_state_t;

    // output port index
    typedef logic [`ROUTE_SEL_WIDTH-1:0] port_sel_t;

endpackage

`default_nettype wire

/* logic/axis_route_table.sv */
// route table mapping each tdest tag to an output port or a drop
`timescale 1ns/1ps
`default_nettype none

`include "axis_route_consts.svh"

module axis_route_table
    import axis_route_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,

    // configuration write port
    input  logic                         cfg_wr,
    input  logic [`ROUTE_DEST_WIDTH-1:0] cfg_dest,
    input  port_sel_t                    cfg_port,
    input  logic                         cfg_drop,

    // lookup
    input  logic [`ROUTE_DEST_WIDTH-1:0] s_axis_tdest,
    output port_sel_t                    route_select,
    output logic                         route_drop
);

    localparam int NUM_ENTRIES = 1 << `ROUTE_DEST_WIDTH;

    port_sel_t entry_port [NUM_ENTRIES];
    logic      entry_drop [NUM_ENTRIES];

    // reset mapping sends tag i to port i mod port count
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entry_port[i] <= port_sel_t'(i % `ROUTE_M_COUNT);
                entry_drop[i] <= 1'b0;
            end
        end else if (cfg_wr) begin
            entry_port[cfg_dest] <= cfg_port;
            entry_drop[cfg_dest] <= cfg_drop;
        end
    end

    // combinational lookup, the demux samples it on a frame's first beat
    assign route_select = entry_port[s_axis_tdest];
    assign route_drop   = entry_drop[s_axis_tdest];

endmodule

`default_nettype wire

/* logic/axis_demux.sv */
// frame-latched stream demultiplexer with a skid buffer on the outputs
`timescale 1ns/1ps
`default_nettype none

`include "axis_route_consts.svh"

module axis_demux
    import axis_route_pkg::*;
#(
    parameter int M_COUNT = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,

    // input stream
    input  logic [`ROUTE_DATA_WIDTH-1:0]         s_axis_tdata,
    input  logic                                 s_axis_tvalid,
    output logic                                 s_axis_tready,
    input  logic                                 s_axis_tlast,

    // output streams, one lane per port
    output logic [M_COUNT*`ROUTE_DATA_WIDTH-1:0] m_axis_tdata,
    output logic [M_COUNT-1:0]                   m_axis_tvalid,
    input  logic [M_COUNT-1:0]                   m_axis_tready,
    output logic [M_COUNT-1:0]                   m_axis_tlast,

    // control
    input  logic                                 enable,
    input  logic                                 drop,
    input  port_sel_t                            select
);

    // frame tracking
    port_sel_t    select_reg;
    port_sel_t    select_ctl;
    port_sel_t    select_next;
    logic         drop_reg;
    logic         drop_ctl;
    logic         drop_next;
    frame_state_t frame_reg;
    frame_state_t frame_next;

    logic s_axis_tready_reg;
    logic s_axis_tready_next;
    logic in_xfer;

    // internal datapath into the skid buffer
    logic [`ROUTE_DATA_WIDTH-1:0] m_axis_tdata_int;
    logic [M_COUNT-1:0]           m_axis_tvalid_int;
    logic                         m_axis_tlast_int;
    logic                         m_axis_tready_int_reg;
    logic                         m_axis_tready_int_early;

    // output and temp registers
    logic [`ROUTE_DATA_WIDTH-1:0] m_axis_tdata_reg;
    logic [M_COUNT-1:0]           m_axis_tvalid_reg;
    logic [M_COUNT-1:0]           m_axis_tvalid_next;
    logic                         m_axis_tlast_reg;
    logic [`ROUTE_DATA_WIDTH-1:0] temp_tdata_reg;
    logic [M_COUNT-1:0]           temp_tvalid_reg;
    logic [M_COUNT-1:0]           temp_tvalid_next;
    logic                         temp_tlast_reg;

    logic store_int_to_output;
    logic store_int_to_temp;
    logic store_temp_to_output;
    logic out_xfer;

    assign s_axis_tready = s_axis_tready_reg && enable;
    assign in_xfer       = s_axis_tvalid && s_axis_tready;

    always_comb begin
        select_next = select_reg;
        select_ctl  = select_reg;
        drop_next   = drop_reg;
        drop_ctl    = drop_reg;
        frame_next  = frame_reg;

        if (in_xfer && s_axis_tlast) begin
            frame_next = FRAME_IDLE;
            drop_next  = 1'b0;
        end

        // first beat of a frame fixes port and drop until tlast
        if (frame_reg == FRAME_IDLE && in_xfer) begin
            select_ctl = select;
            drop_ctl   = drop || (int'(select) >= M_COUNT);
            if (!s_axis_tlast) begin
                select_next = select_ctl;
                drop_next   = drop_ctl;
                frame_next  = FRAME_ACTIVE;
            end
        end

        m_axis_tdata_int  = s_axis_tdata;
        m_axis_tlast_int  = s_axis_tlast;
        m_axis_tvalid_int = '0;
        if (in_xfer && !drop_ctl) begin
            m_axis_tvalid_int[select_ctl] = 1'b1;
        end
    end

    // a dropped frame keeps the input open, but only until its tlast
    assign s_axis_tready_next = m_axis_tready_int_early || drop_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            select_reg        <= '0;
            drop_reg          <= 1'b0;
            frame_reg         <= FRAME_IDLE;
            s_axis_tready_reg <= 1'b0;
        end else begin
            select_reg        <= select_next;
            drop_reg          <= drop_next;
            frame_reg         <= frame_next;
            s_axis_tready_reg <= s_axis_tready_next;
        end
    end

    // data and tlast go to every lane, valid picks the one port
    assign m_axis_tdata  = {M_COUNT{m_axis_tdata_reg}};
    assign m_axis_tvalid = m_axis_tvalid_reg;
    assign m_axis_tlast  = {M_COUNT{m_axis_tlast_reg}};

    assign out_xfer = |(m_axis_tready & m_axis_tvalid);

    // ready next cycle unless the temp register could fill
    assign m_axis_tready_int_early = out_xfer ||
        (!(|temp_tvalid_reg) && (!(|m_axis_tvalid) || !(|m_axis_tvalid_int)));

    always_comb begin
        m_axis_tvalid_next   = m_axis_tvalid_reg;
        temp_tvalid_next     = temp_tvalid_reg;
        store_int_to_output  = 1'b0;
        store_int_to_temp    = 1'b0;
        store_temp_to_output = 1'b0;

        if (m_axis_tready_int_reg) begin
            if (out_xfer || !(|m_axis_tvalid)) begin
                // output free, load it directly
                m_axis_tvalid_next  = m_axis_tvalid_int;
                store_int_to_output = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_tvalid_next  = m_axis_tvalid_int;
                store_int_to_temp = 1'b1;
            end
        end else if (out_xfer) begin
            // drain temp into output
            m_axis_tvalid_next   = temp_tvalid_reg;
            temp_tvalid_next     = '0;
            store_temp_to_output = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_axis_tvalid_reg     <= '0;
            m_axis_tready_int_reg <= 1'b0;
            temp_tvalid_reg       <= '0;
        end else begin
            m_axis_tvalid_reg     <= m_axis_tvalid_next;
            m_axis_tready_int_reg <= m_axis_tready_int_early;
            temp_tvalid_reg       <= temp_tvalid_next;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (store_int_to_output) begin
            m_axis_tdata_reg <= m_axis_tdata_int;
            m_axis_tlast_reg <= m_axis_tlast_int;
        end else if (store_temp_to_output) begin
            m_axis_tdata_reg <= temp_tdata_reg;
            m_axis_tlast_reg <= temp_tlast_reg;
        end

        if (store_int_to_temp) begin
            temp_tdata_reg <= m_axis_tdata_int;
            temp_tlast_reg <= m_axis_tlast_int;
        end
    end

endmodule

`default_nettype wire

/* logic/axis_port_stats.sv */
// delivered frame counters per output port with a read select
`timescale 1ns/1ps
`default_nettype none

`include "axis_route_consts.svh"

module axis_port_stats
    import axis_route_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    // taps of the output lane handshakes
    input  logic [`ROUTE_M_COUNT-1:0]   m_axis_tvalid,
    input  logic [`ROUTE_M_COUNT-1:0]   m_axis_tready,
    input  logic [`ROUTE_M_COUNT-1:0]   m_axis_tlast,

    // counter read
    input  port_sel_t                   stat_sel,
    output logic [`ROUTE_CNT_WIDTH-1:0] stat_count
);

    logic [`ROUTE_CNT_WIDTH-1:0] frame_count [`ROUTE_M_COUNT];
    logic [`ROUTE_M_COUNT-1:0]   frame_done;

    // a frame counts once its last beat leaves the lane
    assign frame_done = m_axis_tvalid & m_axis_tready & m_axis_tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROUTE_M_COUNT; i++) begin
                frame_count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `ROUTE_M_COUNT; i++) begin
                // wraps at counter width
                if (frame_done[i]) begin
                    frame_count[i] <= frame_count[i] + 1'b1;
                end
            end
        end
    end

    assign stat_count = frame_count[stat_sel];

endmodule

`default_nettype wire

/* logic/axis_route_top.sv */
// stream frame router top joining the route table, demux and port counters
`timescale 1ns/1ps
`default_nettype none

`include "axis_route_consts.svh"

module axis_route_top
    import axis_route_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst,

    // input stream
    input  logic [`ROUTE_DATA_WIDTH-1:0]                s_axis_tdata,
    input  logic                                        s_axis_tvalid,
    output logic                                        s_axis_tready,
    input  logic                                        s_axis_tlast,
    input  logic [`ROUTE_DEST_WIDTH-1:0]                s_axis_tdest,

    // output streams
    output logic [`ROUTE_M_COUNT*`ROUTE_DATA_WIDTH-1:0] m_axis_tdata,
    output logic [`ROUTE_M_COUNT-1:0]                   m_axis_tvalid,
    input  logic [`ROUTE_M_COUNT-1:0]                   m_axis_tready,
    output logic [`ROUTE_M_COUNT-1:0]                   m_axis_tlast,

    input  logic                                        enable,

    // route table configuration
    input  logic                                        cfg_wr,
    input  logic [`ROUTE_DEST_WIDTH-1:0]                cfg_dest,
    input  port_sel_t                                   cfg_port,
    input  logic                                        cfg_drop,

    // statistics read
    input  port_sel_t                                   stat_sel,
    output logic [`ROUTE_CNT_WIDTH-1:0]                 stat_count
);

    port_sel_t route_select;
    logic      route_drop;

    axis_route_table u_table (
        .clk          (clk),
        .rst          (rst),
        .cfg_wr       (cfg_wr),
        .cfg_dest     (cfg_dest),
        .cfg_port     (cfg_port),
        .cfg_drop     (cfg_drop),
        .s_axis_tdest (s_axis_tdest),
        .route_select (route_select),
        .route_drop   (route_drop)
    );

    axis_demux #(
        .M_COUNT (`ROUTE_M_COUNT)
    ) u_demux (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tlast  (s_axis_tlast),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .enable        (enable),
        .drop          (route_drop),
        .select        (route_select)
    );

    // counters tap the top level output handshakes
    axis_port_stats u_stats (
        .clk           (clk),
        .rst           (rst),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .stat_sel      (stat_sel),
        .stat_count    (stat_count)
    );

endmodule

`default_nettype wire

/* dv/tb_axis_route.sv */
// random-stimulus testbench for the stream frame router with a reference model
`timescale 1ns/1ps
`default_nettype none

`include "axis_route_consts.svh"

module tb_axis_route
    import axis_route_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int SAMPLE_DELAY  = 40;
    localparam int BEAT_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 500;
    localparam int M             = `ROUTE_M_COUNT;
    localparam int DW            = `ROUTE_DATA_WIDTH;

    logic                         clk;
    logic                         rst;
    logic [DW-1:0]                s_axis_tdata;
    logic                         s_axis_tvalid;
    logic                         s_axis_tready;
    logic                         s_axis_tlast;
    logic [`ROUTE_DEST_WIDTH-1:0] s_axis_tdest;
    logic [M*DW-1:0]              m_axis_tdata;
    logic [M-1:0]                 m_axis_tvalid;
    logic [M-1:0]                 m_axis_tready;
    logic [M-1:0]                 m_axis_tlast;
    logic                         enable;
    logic                         cfg_wr;
    logic [`ROUTE_DEST_WIDTH-1:0] cfg_dest;
    port_sel_t                    cfg_port;
    logic                         cfg_drop;
    port_sel_t                    stat_sel;
    logic [`ROUTE_CNT_WIDTH-1:0]  stat_count;

    // stimulus state
    logic [31:0] rand_state;
    logic        bp_mode;
    logic        gap_mode;

    // reference model with a table copy, the frame latch and expected {tlast, tdata} beats
    port_sel_t   model_port [1 << `ROUTE_DEST_WIDTH];
    logic        model_drop [1 << `ROUTE_DEST_WIDTH];
    port_sel_t   cur_port;
    logic        cur_drop;
    logic [DW:0] exp_mem [M][1024];
    int          wr_ptr [M];
    int          rd_ptr [M];
    int          exp_frames [M];

    axis_route_top u_axis_route_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:16]) % n;
    endfunction

    function automatic logic outputs_pending();
        logic pending;
        pending = 1'b0;
        for (int p = 0; p < M; p++) begin
            if (rd_ptr[p] != wr_ptr[p]) pending = 1'b1;
        end
        return pending;
    endfunction

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    // lane readiness and enable for the coming cycle on the falling edge
    task automatic start_cycle();
        @(negedge clk);
        cfg_wr = 1'b0;
        for (int p = 0; p < M; p++) begin
            m_axis_tready[p] = bp_mode ? (rand_below(10) < 7) : 1'b1;
        end
        enable = gap_mode ? (rand_below(4) != 0) : 1'b1;
    endtask

    // sample just before the rising edge once every handshake has settled
    task automatic close_cycle(output logic accepted);
        logic [DW:0] expected_beat;
        #(SAMPLE_DELAY);
        check_value("m_axis_tvalid one-hot", 32'd1, ($countones(m_axis_tvalid) <= 1));
        if (!enable) check_value("s_axis_tready", 32'd0, s_axis_tready);
        for (int p = 0; p < M; p++) begin
            if (m_axis_tvalid[p] && m_axis_tready[p]) begin
                if (rd_ptr[p] == wr_ptr[p]) begin
                    $display("output beat on port %0d at %0t with no beat expected", p, $time);
                    end_with_failure();
                end
                expected_beat = exp_mem[p][rd_ptr[p]];
                rd_ptr[p]++;
                check_value($sformatf("m_axis_tdata[%0d]", p), expected_beat[DW-1:0],
                            m_axis_tdata[p*DW +: DW]);
                check_value($sformatf("m_axis_tlast[%0d]", p), expected_beat[DW], m_axis_tlast[p]);
            end
        end
        accepted = s_axis_tvalid && s_axis_tready;
    endtask

    // port and drop are fixed by the table at the first beat
    task automatic record_input_beat(input logic [`ROUTE_DEST_WIDTH-1:0] dest,
                                     input logic [DW-1:0] data, input logic last,
                                     input logic first);
        if (first) begin
            cur_port = model_port[dest];
            cur_drop = model_drop[dest];
        end
        if (!cur_drop) begin
            exp_mem[cur_port][wr_ptr[cur_port]] = {last, data};
            wr_ptr[cur_port]++;
            if (last) exp_frames[cur_port]++;
        end
    endtask

    task automatic send_frame(input logic [`ROUTE_DEST_WIDTH-1:0] dest, input int len);
        logic [31:0]   r;
        logic [DW-1:0] data;
        logic          accepted;
        int            waited;
        for (int i = 0; i < len; i++) begin
            r = next_rand();
            data = r[23:16];
            // occasional idle cycle before a beat is offered
            if (rand_below(5) == 0) begin
                start_cycle();
                s_axis_tvalid = 1'b0;
                close_cycle(accepted);
            end
            accepted = 1'b0;
            waited = 0;
            while (!accepted && waited < BEAT_TIMEOUT) begin
                start_cycle();
                s_axis_tvalid = 1'b1;
                s_axis_tdata  = data;
                s_axis_tlast  = (i == len - 1);
                s_axis_tdest  = dest;
                close_cycle(accepted);
                waited++;
            end
            if (!accepted) begin
                $display("timeout: beat %0d of a frame to tdest %0d was never accepted", i, dest);
                end_with_failure();
            end
            record_input_beat(dest, data, i == len - 1, i == 0);
        end
    endtask

    task automatic send_random_frames(input int count);
        for (int f = 0; f < count; f++) begin
            send_frame(rand_below(1 << `ROUTE_DEST_WIDTH), 1 + rand_below(6));
        end
    endtask

    task automatic write_route(input logic [`ROUTE_DEST_WIDTH-1:0] dest, input port_sel_t port,
                               input logic drop);
        logic accepted;
        start_cycle();
        s_axis_tvalid = 1'b0;
        cfg_wr   = 1'b1;
        cfg_dest = dest;
        cfg_port = port;
        cfg_drop = drop;
        close_cycle(accepted);
        model_port[dest] = port;
        model_drop[dest] = drop;
    endtask

    task automatic drain_outputs();
        logic accepted;
        int   waited;
        bp_mode  = 1'b0;
        gap_mode = 1'b0;
        waited   = 0;
        while (outputs_pending() && waited < DRAIN_TIMEOUT) begin
            start_cycle();
            s_axis_tvalid = 1'b0;
            close_cycle(accepted);
            waited++;
        end
        if (outputs_pending()) begin
            $display("timeout: expected beats never left the output lanes");
            end_with_failure();
        end
    endtask

    task automatic check_stats();
        logic accepted;
        for (int p = 0; p < M; p++) begin
            start_cycle();
            s_axis_tvalid = 1'b0;
            stat_sel = port_sel_t'(p);
            close_cycle(accepted);
            check_value($sformatf("stat_count[%0d]", p), exp_frames[p], stat_count);
        end
    endtask

    initial begin
        rand_state    = 32'h838f;
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        s_axis_tdest  = '0;
        m_axis_tready = '0;
        enable        = 1'b1;
        cfg_wr        = 1'b0;
        cfg_dest      = '0;
        cfg_port      = '0;
        cfg_drop      = 1'b0;
        stat_sel      = '0;
        bp_mode       = 1'b0;
        gap_mode      = 1'b0;
        for (int i = 0; i < (1 << `ROUTE_DEST_WIDTH); i++) begin
            model_port[i] = port_sel_t'(i % M);
            model_drop[i] = 1'b0;
        end
        for (int p = 0; p < M; p++) begin
            wr_ptr[p]     = 0;
            rd_ptr[p]     = 0;
            exp_frames[p] = 0;
        end
        repeat (10) @(negedge clk);
        check_value("m_axis_tvalid", 32'd0, m_axis_tvalid);
        check_value("s_axis_tready", 32'd0, s_axis_tready);
        rst = 1'b0;

        // reset table with every lane ready
        send_random_frames(12);

        // remapped entries with one of them dropping
        for (int w = 0; w < 3; w++) begin
            write_route(rand_below(8), rand_below(M), rand_below(4) == 0);
        end
        write_route(3'd5, 2'd0, 1'b1);
        write_route(3'd2, 2'd3, 1'b0);
        send_frame(3'd5, 4);
        send_frame(3'd2, 3);
        send_random_frames(14);

        // random back-pressure per lane
        bp_mode = 1'b1;
        send_random_frames(30);

        // enable gaps followed by plain traffic
        gap_mode = 1'b1;
        send_random_frames(20);
        gap_mode = 1'b0;
        send_random_frames(8);

        drain_outputs();
        check_stats();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/axis_route_pkg.sv
logic/axis_route_table.sv
logic/axis_demux.sv
logic/axis_port_stats.sv
logic/axis_route_top.sv
dv/tb_axis_route.sv

/* Bender.yml */
package:
  name: axis_route

sources:
  - include_dirs:
      - logic
    files:
      - logic/axis_route_pkg.sv
      - logic/axis_route_table.sv
      - logic/axis_demux.sv
      - logic/axis_port_stats.sv
      - logic/axis_route_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_axis_route.sv
